/* design/word_pkg.sv */
/*
 * Data word and counter nibble types
 * Idle bus value and flag word bit positions
 */

package word_pkg;

   // Counter stage geometry
   localparam int NIBBLE_W     = 4;
   localparam int NIBBLE_COUNT = 4;
   localparam int WORD_W       = NIBBLE_W * NIBBLE_COUNT;

   // Word on the bus, in the registers and on the console
   typedef logic [WORD_W-1:0] word_t;

   // One counter stage of the program counter
   typedef logic [NIBBLE_W-1:0] nibble_t;

   // Nothing enabled on the read bus reads as pulled high
   localparam word_t BUS_IDLE = '1;

   // Flag word layout
   localparam int FLAG_L_BIT = 0;
   localparam int FLAG_I_BIT = 1;

endpackage

/* design/ctl_pkg.sv */
/*
 * Register select type and select codes
 * Shared by the write decoder and the read bus
 */

package ctl_pkg;

   // Width of a register select
   localparam int SEL_W = 2;

   // Register select on both write and read side
   typedef logic [SEL_W-1:0] reg_sel_t;

   //////////////////////////////////////////////////
   // Select codes
   //////////////////////////////////////////////////

   // Program counter
   localparam reg_sel_t SEL_PC    = 2'd0;

   // Accumulator
   localparam reg_sel_t SEL_AC    = 2'd1;

   // Memory address register
   localparam reg_sel_t SEL_MAR   = 2'd2;

   // L and I flags packed into one word
   localparam reg_sel_t SEL_FLAGS = 2'd3;

endpackage

/* design/reg_view_if.sv */
/*
 * Register view interface
 * Current value of every register with one modport per holder
 */

`timescale 1ns/1ns

interface reg_view_if;
   import word_pkg::*;

   // Program counter
   word_t pc;

   // Accumulator and memory address register
   word_t ac;
   word_t mar;

   // Single bit flags
   logic  flag_l;
   logic  flag_i;

   // Counter block owns pc
   modport pc_src (output pc);

   // Write block owns ac and mar
   modport data_src (output ac, output mar);

   // Flag block owns both flags
   modport flag_src (output flag_l, output flag_i);

   // Read bus and console see everything
   modport view (
      input pc,
      input ac,
      input mar,
      input flag_l,
      input flag_i
   );

endinterface

/* design/reg_write.sv */
/*
 * Write strobe decoder
 * Accumulator and memory address register with load strobes out
 */

`timescale 1ns/1ns

module reg_write (
   input  logic              latch,
   input  logic              reset,
   input  word_pkg::word_t   d,
   input  logic              wr,
   input  ctl_pkg::reg_sel_t wr_sel,
   output logic              load_pc,
   output logic              load_l,
   reg_view_if.data_src      view
);
   import ctl_pkg::*;

   // Local load strobes
   logic wr_ac;
   logic wr_mar;

   //////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////

   // One strobe per select while wr is high
   always_comb begin
      load_pc = 1'b0;
      wr_ac   = 1'b0;
      wr_mar  = 1'b0;
      load_l  = 1'b0;
      if (wr) begin
         case (wr_sel)
            SEL_PC: begin
               load_pc = 1'b1;
            end
            SEL_AC: begin
               wr_ac = 1'b1;
            end
            SEL_MAR: begin
               wr_mar = 1'b1;
            end
            SEL_FLAGS: begin
               // Only bit 0 of d lands in L
               load_l = 1'b1;
            end
            default: begin
               load_pc = 1'b0;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Data registers
   //////////////////////////////////////////////////

   // Accumulator
   always_ff @(posedge latch) begin
      if (reset) begin
         view.ac <= '0;
      end else if (wr_ac) begin
         view.ac <= d;
      end
   end

   // Memory address register
   always_ff @(posedge latch) begin
      if (reset) begin
         view.mar <= '0;
      end else if (wr_mar) begin
         view.mar <= d;
      end
   end

   // A write must name a register
   // X here would leave every holder guessing
   a_wr_sel_known: assert property (
      @(posedge latch) disable iff (reset)
      wr |-> !$isunknown(wr_sel)
   ) else $error("wr_sel unknown during write");

endmodule

/* design/inc_reg16.sv */
/*
 * Program counter built from four chained nibble counters
 * Parallel load with increment and decrement
 */

`timescale 1ns/1ns

module inc_reg16 (
   input  logic            latch,
   input  logic            reset,
   input  word_pkg::word_t d,
   input  logic            load_pc,
   input  logic            pc_inc,
   input  logic            pc_dec,
   reg_view_if.pc_src      view
);
   import word_pkg::*;

   // Stage values, least significant first
   nibble_t stage_q [NIBBLE_COUNT];

   // Carry and borrow into each stage
   logic [NIBBLE_COUNT-1:0] carry;
   logic [NIBBLE_COUNT-1:0] borrow;

   // Both count strobes together cancel out
   assign carry[0]  = pc_inc && !pc_dec;
   assign borrow[0] = pc_dec && !pc_inc;

   //////////////////////////////////////////////////
   // Nibble stages
   //////////////////////////////////////////////////

   for (genvar i = 0; i < NIBBLE_COUNT; i++) begin : g_stage
      // Reset over load over count
      always_ff @(posedge latch) begin
         if (reset) begin
            stage_q[i] <= '0;
         end else if (load_pc) begin
            stage_q[i] <= d[i*NIBBLE_W +: NIBBLE_W];
         end else if (carry[i]) begin
            stage_q[i] <= stage_q[i] + nibble_t'(1);
         end else if (borrow[i]) begin
            stage_q[i] <= stage_q[i] - nibble_t'(1);
         end
      end

      // Ripple to the next stage
      // Carry out of the top stage is dropped so the count wraps
      if (i < NIBBLE_COUNT - 1) begin : g_chain
         assign carry[i+1]  = carry[i] && (stage_q[i] == '1);
         assign borrow[i+1] = borrow[i] && (stage_q[i] == '0);
      end
   end

   // Stages side by side form the counter word
   always_comb begin
      for (int n = 0; n < NIBBLE_COUNT; n++) begin
         view.pc[n*NIBBLE_W +: NIBBLE_W] = stage_q[n];
      end
   end

   // Carry must ripple through every stage on the wrap
   a_wrap_to_zero: assert property (
      @(posedge latch) disable iff (reset)
      (carry[0] && !load_pc && (view.pc == '1)) |=> (view.pc == '0)
   ) else $error("pc did not wrap to zero");

endmodule

/* design/flag_unit.sv */
/*
 * L flag with load, clear and toggle
 * I flag with set and clear
 */

`timescale 1ns/1ns

module flag_unit (
   input  logic         latch,
   input  logic         reset,
   input  logic         load_l,
   input  logic         l_data,   // bit 0 of the write word
   input  logic         l_toggle,
   input  logic         l_clear,
   input  logic         i_set,
   input  logic         i_clear,
   reg_view_if.flag_src view
);

   //////////////////////////////////////////////////
   // L flag
   //////////////////////////////////////////////////

   // J and K inputs of the L flip-flop
   logic l_j;
   logic l_k;

   // Load sets or resets by data
   // Toggle drives both so it wins over load
   assign l_j = (load_l && l_data) || l_toggle;
   assign l_k = (load_l && !l_data) || l_toggle;

   // Clear sits on top of the JK update
   always_ff @(posedge latch) begin
      if (reset || l_clear) begin
         view.flag_l <= 1'b0;
      end else begin
         case ({l_j, l_k})
            2'b11: view.flag_l <= !view.flag_l;
            2'b10: view.flag_l <= 1'b1;
            2'b01: view.flag_l <= 1'b0;
            default: view.flag_l <= view.flag_l;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // I flag
   //////////////////////////////////////////////////

   // Clear wins over set
   always_ff @(posedge latch) begin
      if (reset || i_clear) begin
         view.flag_i <= 1'b0;
      end else if (i_set) begin
         view.flag_i <= 1'b1;
      end
   end

   // Controller never asks for both at once
   a_i_exclusive: assert property (
      @(posedge latch) disable iff (reset)
      !(i_set && i_clear)
   ) else $error("i_set and i_clear high together");

endmodule

/* design/bus_drive.sv */
/*
 * Read bus source select
 * Flag word assembly and pulled-high idle value
 */

`timescale 1ns/1ns

module bus_drive (
   input  logic              latch,
   input  logic              reset,
   reg_view_if.view          view,
   input  logic              rd_en,
   input  ctl_pkg::reg_sel_t rd_sel,
   output word_pkg::word_t   q
);
   import word_pkg::*;
   import ctl_pkg::*;

   // Both flags placed in an otherwise empty word
   word_t flag_word;

   always_comb begin
      flag_word             = '0;
      flag_word[FLAG_L_BIT] = view.flag_l;
      flag_word[FLAG_I_BIT] = view.flag_i;
   end

   //////////////////////////////////////////////////
   // Source mux
   //////////////////////////////////////////////////

   // Stands in for the output enable buffers
   // Nothing enabled reads all ones
   always_comb begin
      if (!rd_en) begin
         q = BUS_IDLE;
      end else begin
         case (rd_sel)
            SEL_PC:    q = view.pc;
            SEL_AC:    q = view.ac;
            SEL_MAR:   q = view.mar;
            SEL_FLAGS: q = flag_word;
            default:   q = BUS_IDLE;
         endcase
      end
   end

   // Every holder is cleared by reset
   // So the bus must stay clean once reset is gone
   a_q_known: assert property (
      @(posedge latch) disable iff (reset)
      !$isunknown(q)
   ) else $error("read bus carries unknown bits");

endmodule

/* design/cpu_regs.sv */
/*
 * Register section top level
 * Write decode, program counter, flags and read bus
 */

`timescale 1ns/1ns

module cpu_regs (
   input  logic              latch,
   input  logic              reset,
   input  word_pkg::word_t   d,
   input  logic              wr,
   input  ctl_pkg::reg_sel_t wr_sel,
   input  logic              pc_inc,
   input  logic              pc_dec,
   input  logic              l_toggle,
   input  logic              l_clear,
   input  logic              i_set,
   input  logic              i_clear,
   input  logic              rd_en,
   input  ctl_pkg::reg_sel_t rd_sel,
   output word_pkg::word_t   q,
   output word_pkg::word_t   pc_con,
   output word_pkg::word_t   ac_con,
   output word_pkg::word_t   mar_con,
   output logic              flag_l,
   output logic              flag_i
);
   import word_pkg::*;

   // Strobes from the write decoder
   logic load_pc;
   logic load_l;

   // Current value of every register
   reg_view_if regs ();

   // Decoder with accumulator and address register
   reg_write reg_write_inst (
      .latch   (latch),
      .reset   (reset),
      .d       (d),
      .wr      (wr),
      .wr_sel  (wr_sel),
      .load_pc (load_pc),
      .load_l  (load_l),
      .view    (regs.data_src)
   );

   // Program counter
   inc_reg16 inc_reg16_inst (
      .latch   (latch),
      .reset   (reset),
      .d       (d),
      .load_pc (load_pc),
      .pc_inc  (pc_inc),
      .pc_dec  (pc_dec),
      .view    (regs.pc_src)
   );

   // L takes only its bit of the write word
   flag_unit flag_unit_inst (
      .latch    (latch),
      .reset    (reset),
      .load_l   (load_l),
      .l_data   (d[FLAG_L_BIT]),
      .l_toggle (l_toggle),
      .l_clear  (l_clear),
      .i_set    (i_set),
      .i_clear  (i_clear),
      .view     (regs.flag_src)
   );

   // Read bus
   bus_drive bus_drive_inst (
      .latch  (latch),
      .reset  (reset),
      .view   (regs.view),
      .rd_en  (rd_en),
      .rd_sel (rd_sel),
      .q      (q)
   );

   // Console lamps
   assign pc_con  = regs.pc;
   assign ac_con  = regs.ac;
   assign mar_con = regs.mar;
   assign flag_l  = regs.flag_l;
   assign flag_i  = regs.flag_i;

endmodule

/* verif/cpu_regs_tb.sv */
/*
 * Testbench for the register section
 * Clock, reset, stimulus table, compare tasks and watchdog
 */

`timescale 1ns/1ns

module cpu_regs_tb;
   import word_pkg::*;
   import ctl_pkg::*;

   localparam int PERIOD       = 100;
   localparam int DRIVE_DELAY  = 10;
   localparam int RESET_CYCLES = 3;

   // Control bits of a table row are ORed together
   localparam logic [8:0] NONE = 9'h000;
   localparam logic [8:0] RST  = 9'h100;
   localparam logic [8:0] WR   = 9'h080;
   localparam logic [8:0] INC  = 9'h040;
   localparam logic [8:0] DEC  = 9'h020;
   localparam logic [8:0] TOG  = 9'h010;
   localparam logic [8:0] LCLR = 9'h008;
   localparam logic [8:0] ISET = 9'h004;
   localparam logic [8:0] ICLR = 9'h002;
   localparam logic [8:0] RD   = 9'h001;

   // Stimulus and expected outputs after the next edge
   typedef struct packed {
      logic [8:0] ctl;
      reg_sel_t   wr_sel;
      reg_sel_t   rd_sel;
      word_t      d;
      word_t      q;
      word_t      pc;
      word_t      ac;
      word_t      mar;
      logic       fl;
      logic       fi;
   } row_t;

   // DUT ports
   logic     latch;
   logic     reset;
   word_t    d;
   logic     wr;
   reg_sel_t wr_sel;
   logic     pc_inc;
   logic     pc_dec;
   logic     l_toggle;
   logic     l_clear;
   logic     i_set;
   logic     i_clear;
   logic     rd_en;
   reg_sel_t rd_sel;
   word_t    q;
   word_t    pc_con;
   word_t    ac_con;
   word_t    mar_con;
   logic     flag_l;
   logic     flag_i;

   row_t rows [$];
   bit   table_ready = 1'b0;
   int   cur_row     = 0;

   cpu_regs cpu_regs_inst (.*);

   // Free running clock
   initial begin
      latch = 1'b0;
      forever #(PERIOD/2) latch = ~latch;
   end

   //////////////////////////////////////////////////
   // Table helpers and compare tasks
   //////////////////////////////////////////////////

   task automatic add_row(input logic [8:0] ctl, input reg_sel_t ws, input reg_sel_t rs,
                          input word_t dv, input word_t eq, input word_t epc,
                          input word_t eac, input word_t emar, input logic el,
                          input logic ei);
      row_t r;
      r.ctl    = ctl;
      r.wr_sel = ws;
      r.rd_sel = rs;
      r.d      = dv;
      r.q      = eq;
      r.pc     = epc;
      r.ac     = eac;
      r.mar    = emar;
      r.fl     = el;
      r.fi     = ei;
      rows.push_back(r);
   endtask

   task automatic drive_row(input row_t r);
      reset    = |(r.ctl & RST);
      wr       = |(r.ctl & WR);
      pc_inc   = |(r.ctl & INC);
      pc_dec   = |(r.ctl & DEC);
      l_toggle = |(r.ctl & TOG);
      l_clear  = |(r.ctl & LCLR);
      i_set    = |(r.ctl & ISET);
      i_clear  = |(r.ctl & ICLR);
      rd_en    = |(r.ctl & RD);
      wr_sel   = r.wr_sel;
      rd_sel   = r.rd_sel;
      d        = r.d;
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("** Error: %s expected %h got %h in row %0d", name, exp, act, cur_row);
         $display("Test FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s expected %h got %h in row %0d", name, exp, act, cur_row);
         $display("Test FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////

   task automatic build_table();
      // Idle after reset, then pc read back
      add_row(NONE,       SEL_PC,    SEL_PC,    'h0000, 'hFFFF, 'h0000, 'h0000, 'h0000, 0, 0);
      add_row(RD,         SEL_PC,    SEL_PC,    'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 0, 0);
      // Register writes with read back
      add_row(WR|RD,      SEL_AC,    SEL_AC,    'h1234, 'h1234, 'h0000, 'h1234, 'h0000, 0, 0);
      add_row(WR|RD,      SEL_MAR,   SEL_MAR,   'h0ABC, 'h0ABC, 'h0000, 'h1234, 'h0ABC, 0, 0);
      add_row(WR|RD,      SEL_PC,    SEL_PC,    'h00FF, 'h00FF, 'h00FF, 'h1234, 'h0ABC, 0, 0);
      // Carry, borrow and cancel
      add_row(INC|RD,     SEL_PC,    SEL_PC,    'h0000, 'h0100, 'h0100, 'h1234, 'h0ABC, 0, 0);
      add_row(DEC|RD,     SEL_PC,    SEL_PC,    'h0000, 'h00FF, 'h00FF, 'h1234, 'h0ABC, 0, 0);
      add_row(INC|DEC|RD, SEL_PC,    SEL_PC,    'h0000, 'h00FF, 'h00FF, 'h1234, 'h0ABC, 0, 0);
      // Wrap both ways
      add_row(WR,         SEL_PC,    SEL_PC,    'hFFFF, 'hFFFF, 'hFFFF, 'h1234, 'h0ABC, 0, 0);
      add_row(INC|RD,     SEL_PC,    SEL_PC,    'h0000, 'h0000, 'h0000, 'h1234, 'h0ABC, 0, 0);
      add_row(DEC|RD,     SEL_PC,    SEL_PC,    'h0000, 'hFFFF, 'hFFFF, 'h1234, 'h0ABC, 0, 0);
      // Load beats increment
      add_row(WR|INC|RD,  SEL_PC,    SEL_PC,    'h2000, 'h2000, 'h2000, 'h1234, 'h0ABC, 0, 0);
      add_row(INC|RD,     SEL_PC,    SEL_PC,    'h0000, 'h2001, 'h2001, 'h1234, 'h0ABC, 0, 0);
      add_row(WR|RD,      SEL_PC,    SEL_PC,    'h0FFF, 'h0FFF, 'h0FFF, 'h1234, 'h0ABC, 0, 0);
      add_row(INC|RD,     SEL_PC,    SEL_PC,    'h0000, 'h1000, 'h1000, 'h1234, 'h0ABC, 0, 0);
      // L takes only bit 0 of the write word
      add_row(WR|RD,      SEL_FLAGS, SEL_FLAGS, 'hFFFF, 'h0001, 'h1000, 'h1234, 'h0ABC, 1, 0);
      add_row(WR|RD,      SEL_FLAGS, SEL_FLAGS, 'h0002, 'h0000, 'h1000, 'h1234, 'h0ABC, 0, 0);
      // Toggle, clear over toggle, toggle over load
      add_row(TOG|RD,     SEL_PC,    SEL_FLAGS, 'h0000, 'h0001, 'h1000, 'h1234, 'h0ABC, 1, 0);
      add_row(TOG|LCLR|RD, SEL_PC,   SEL_FLAGS, 'h0000, 'h0000, 'h1000, 'h1234, 'h0ABC, 0, 0);
      add_row(TOG|RD,     SEL_PC,    SEL_FLAGS, 'h0000, 'h0001, 'h1000, 'h1234, 'h0ABC, 1, 0);
      add_row(WR|TOG|RD,  SEL_FLAGS, SEL_FLAGS, 'h0001, 'h0000, 'h1000, 'h1234, 'h0ABC, 0, 0);
      add_row(WR|RD,      SEL_FLAGS, SEL_FLAGS, 'h0001, 'h0001, 'h1000, 'h1234, 'h0ABC, 1, 0);
      // I flag and the flag word layout
      add_row(ISET|RD,    SEL_PC,    SEL_FLAGS, 'h0000, 'h0003, 'h1000, 'h1234, 'h0ABC, 1, 1);
      add_row(ICLR|RD,    SEL_PC,    SEL_FLAGS, 'h0000, 'h0001, 'h1000, 'h1234, 'h0ABC, 1, 0);
      add_row(ISET,       SEL_PC,    SEL_FLAGS, 'h0000, 'hFFFF, 'h1000, 'h1234, 'h0ABC, 1, 1);
      add_row(LCLR|RD,    SEL_PC,    SEL_FLAGS, 'h0000, 'h0002, 'h1000, 'h1234, 'h0ABC, 0, 1);
      // Reset mid-run beats every strobe
      add_row(RST|WR|INC|TOG|ISET|RD, SEL_AC, SEL_AC, 'h5555, 'h0000, 'h0000, 'h0000, 'h0000,
              0, 0);
      add_row(NONE,       SEL_PC,    SEL_PC,    'h0000, 'hFFFF, 'h0000, 'h0000, 'h0000, 0, 0);
      add_row(WR|RD,      SEL_AC,    SEL_AC,    'hBEEF, 'hBEEF, 'h0000, 'hBEEF, 'h0000, 0, 0);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      reset    = 1'b1;
      d        = '0;
      wr       = 1'b0;
      wr_sel   = SEL_PC;
      pc_inc   = 1'b0;
      pc_dec   = 1'b0;
      l_toggle = 1'b0;
      l_clear  = 1'b0;
      i_set    = 1'b0;
      i_clear  = 1'b0;
      rd_en    = 1'b0;
      rd_sel   = SEL_PC;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge latch);
      #DRIVE_DELAY;
      // Drive after one edge, check after the next, then drive again
      for (int i = 0; i < rows.size(); i++) begin
         cur_row = i;
         drive_row(rows[i]);
         @(posedge latch);
         #DRIVE_DELAY;
         check_word("q", rows[i].q, q);
         check_word("pc_con", rows[i].pc, pc_con);
         check_word("ac_con", rows[i].ac, ac_con);
         check_word("mar_con", rows[i].mar, mar_con);
         check_flag("flag_l", rows[i].fl, flag_l);
         check_flag("flag_i", rows[i].fi, flag_i);
      end
      $display("Test OK");
      $finish;
   end

   // Watchdog sized from reset, table length and some slack
   initial begin
      wait (table_ready);
      #((RESET_CYCLES + rows.size() + 10) * PERIOD);
      $display("Timeout: the table did not finish within the expected time");
      $display("Test FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

/* sim.f */
design/word_pkg.sv
design/ctl_pkg.sv
design/reg_view_if.sv
design/reg_write.sv
design/inc_reg16.sv
design/flag_unit.sv
design/bus_drive.sv
design/cpu_regs.sv
verif/cpu_regs_tb.sv
